/* src/regfile_pkg.sv */
package regfile_pkg;

    // Register file geometry
    localparam int GPR_COUNT  = 8;
    localparam int GPR_ADDR_W = 3;
    localparam int REG_W      = 32;
    localparam int UPPER_W    = 16;  // Bits 31:16
    localparam int BYTE_W     = 8;

    // Sections per register, listed from the bottom up
    localparam int SEC_COUNT = 3;
    localparam int SEC_L     = 0;    // Bits 7:0
    localparam int SEC_H     = 1;    // Bits 15:8
    localparam int SEC_E     = 2;    // Upper half

    // Access size of a write, an allocation or a read.
    // Code 3 is not a legal size.
    typedef enum logic [1:0] {
        SIZE_8  = 2'd0,
        SIZE_16 = 2'd1,
        SIZE_32 = 2'd2
    } size_t;

endpackage

/* src/gpr_section_decode.sv */
`timescale 1ns/1ps

module gpr_section_decode
    import regfile_pkg::*;
(
    input  logic                           en,
    input  logic [GPR_ADDR_W-1:0]          addr,
    input  size_t                          size,
    output logic [GPR_COUNT*SEC_COUNT-1:0] sec_en
);

    logic [GPR_ADDR_W-1:0] byte_reg;
    logic                  byte_hi;
    logic [GPR_ADDR_W-1:0] tgt_reg;
    logic [SEC_COUNT-1:0]  tgt_sec;

    // Byte addresses 4..7 name the high byte of registers 0..3
    assign byte_hi  = addr[GPR_ADDR_W-1];
    assign byte_reg = {1'b0, addr[GPR_ADDR_W-2:0]};

    always_comb begin
        tgt_reg = addr;
        tgt_sec = '0;
        case (size)
            SIZE_32: tgt_sec = '1;
            SIZE_16: begin
                tgt_sec[SEC_L] = 1'b1;
                tgt_sec[SEC_H] = 1'b1;
            end
            SIZE_8: begin
                tgt_reg = byte_reg;
                if (byte_hi) begin
                    tgt_sec[SEC_H] = 1'b1;
                end else begin
                    tgt_sec[SEC_L] = 1'b1;
                end
            end
            default: tgt_sec = '0;  // Illegal size, nothing enabled
        endcase
    end

    always_comb begin
        sec_en = '0;
        for (int i = 0; i < GPR_COUNT; i++) begin
            if (en && tgt_reg == GPR_ADDR_W'(i)) begin
                sec_en[i*SEC_COUNT +: SEC_COUNT] = tgt_sec;
            end
        end
    end

    always_comb begin
        assert final (!(en && size == 2'd3))
            else $error("section decode enabled with illegal size code 3");
    end

endmodule

/* src/gpr_slot.sv */
`timescale 1ns/1ps

module gpr_slot
    import regfile_pkg::*;
#(
    parameter int TAG_W = 7
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [SEC_COUNT-1:0] wr_sec,
    input  logic [REG_W-1:0]     wr_data,
    input  logic [SEC_COUNT-1:0] alloc_sec,
    input  logic [TAG_W-1:0]     alloc_id,
    input  logic                 bcast_en,
    input  logic [TAG_W-1:0]     bcast_id,
    input  logic                 tag_flush,
    output logic [REG_W-1:0]     value,
    output logic [SEC_COUNT-1:0] sec_valid
);

    logic [UPPER_W-1:0]   sec_e;
    logic [BYTE_W-1:0]    sec_h;
    logic [BYTE_W-1:0]    sec_l;
    logic [BYTE_W-1:0]    h_lane;
    logic [TAG_W-1:0]     tag_id [SEC_COUNT];
    logic [SEC_COUNT-1:0] bcast_hit;

    // High byte alone comes in on the low lane (AH/CH/DH/BH writes)
    assign h_lane = wr_sec[SEC_L] ? wr_data[2*BYTE_W-1 -: BYTE_W] : wr_data[BYTE_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sec_e <= '0;
            sec_h <= '0;
            sec_l <= '0;
        end else begin
            if (wr_sec[SEC_L]) sec_l <= wr_data[BYTE_W-1:0];
            if (wr_sec[SEC_H]) sec_h <= h_lane;
            if (wr_sec[SEC_E]) sec_e <= wr_data[REG_W-1 -: UPPER_W];
        end
    end

    assign value = {sec_e, sec_h, sec_l};

    always_comb begin
        for (int s = 0; s < SEC_COUNT; s++) begin
            bcast_hit[s] = bcast_en && (tag_id[s] == bcast_id);
        end
    end

    // Flush beats allocate, allocate beats broadcast
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sec_valid <= '0;
            for (int s = 0; s < SEC_COUNT; s++) begin
                tag_id[s] <= '0;
            end
        end else begin
            for (int s = 0; s < SEC_COUNT; s++) begin
                if (tag_flush) begin
                    sec_valid[s] <= 1'b0;
                end else if (alloc_sec[s]) begin
                    sec_valid[s] <= 1'b1;
                    tag_id[s]    <= alloc_id;
                end else if (bcast_hit[s]) begin
                    sec_valid[s] <= 1'b0;
                end
            end
        end
    end

    // A pending bit only comes up from an allocation of its own section
    for (genvar s = 0; s < SEC_COUNT; s++) begin : g_valid_chk
        assert property (@(posedge clk) disable iff (!rst_n)
            $rose(sec_valid[s]) |-> $past(alloc_sec[s] && !tag_flush))
            else $error("section %0d became pending without an allocation", s);
    end

endmodule

/* src/gpr_read_port.sv */
`timescale 1ns/1ps

module gpr_read_port
    import regfile_pkg::*;
(
    input  logic [GPR_ADDR_W-1:0]          rd_addr,
    input  size_t                          rd_size,
    input  logic [GPR_COUNT*REG_W-1:0]     values,
    input  logic [GPR_COUNT*SEC_COUNT-1:0] valids,
    output logic [REG_W-1:0]               rd_data,
    output logic [SEC_COUNT-1:0]           rd_pending
);

    localparam int HALF_W = 2 * BYTE_W;

    logic                  byte_hi;
    logic [GPR_ADDR_W-1:0] sel_reg;
    logic [REG_W-1:0]      sel_val;
    logic [SEC_COUNT-1:0]  sel_vld;
    logic [BYTE_W-1:0]     byte_val;
    logic                  byte_vld;

    // Same remap as the write side, only for byte reads
    assign byte_hi = (rd_size == SIZE_8) && rd_addr[GPR_ADDR_W-1];
    assign sel_reg = (rd_size == SIZE_8) ? {1'b0, rd_addr[GPR_ADDR_W-2:0]} : rd_addr;

    assign sel_val = values[sel_reg*REG_W +: REG_W];
    assign sel_vld = valids[sel_reg*SEC_COUNT +: SEC_COUNT];

    always_comb begin
        if (byte_hi) begin
            byte_val = sel_val[HALF_W-1 -: BYTE_W];
            byte_vld = sel_vld[SEC_H];
        end else begin
            byte_val = sel_val[BYTE_W-1:0];
            byte_vld = sel_vld[SEC_L];
        end
    end

    always_comb begin
        rd_data    = '0;
        rd_pending = '0;
        case (rd_size)
            SIZE_32: begin
                rd_data    = sel_val;
                rd_pending = sel_vld;
            end
            SIZE_16: begin
                rd_data = {{(REG_W-HALF_W){sel_val[HALF_W-1]}}, sel_val[HALF_W-1:0]};
                rd_pending[SEC_L] = sel_vld[SEC_L];
                rd_pending[SEC_H] = sel_vld[SEC_H];
            end
            SIZE_8: begin
                rd_data = {{(REG_W-BYTE_W){byte_val[BYTE_W-1]}}, byte_val};
                rd_pending[0] = byte_vld;  // Always in bit 0
            end
            default: begin
                rd_data    = '0;
                rd_pending = '0;
            end
        endcase
    end

endmodule

/* src/regfile_top.sv */
`timescale 1ns/1ps

module regfile_top
    import regfile_pkg::*;
#(
    parameter int TAG_W = 7
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // Write port
    input  logic                  wr_en,
    input  logic [GPR_ADDR_W-1:0] wr_addr,
    input  size_t                 wr_size,
    input  logic [REG_W-1:0]      wr_data,
    // Tag allocation
    input  logic                  alloc_en,
    input  logic [GPR_ADDR_W-1:0] alloc_addr,
    input  size_t                 alloc_size,
    input  logic [TAG_W-1:0]      alloc_id,
    // Result broadcast
    input  logic                  bcast_en,
    input  logic [TAG_W-1:0]      bcast_id,
    input  logic                  tag_flush,
    // Read port
    input  logic [GPR_ADDR_W-1:0] rd_addr,
    input  size_t                 rd_size,
    output logic [REG_W-1:0]      rd_data,
    output logic [SEC_COUNT-1:0]  rd_pending
);

    logic [GPR_COUNT*SEC_COUNT-1:0] wr_sec_en;
    logic [GPR_COUNT*SEC_COUNT-1:0] alloc_sec_en;
    logic [GPR_COUNT*REG_W-1:0]     values;
    logic [GPR_COUNT*SEC_COUNT-1:0] valids;

    gpr_section_decode u_wr_decode (
        .en     (wr_en),
        .addr   (wr_addr),
        .size   (wr_size),
        .sec_en (wr_sec_en)
    );

    gpr_section_decode u_alloc_decode (
        .en     (alloc_en),
        .addr   (alloc_addr),
        .size   (alloc_size),
        .sec_en (alloc_sec_en)
    );

    for (genvar i = 0; i < GPR_COUNT; i++) begin : g_slot
        gpr_slot #(
            .TAG_W (TAG_W)
        ) u_slot (
            .clk       (clk),
            .rst_n     (rst_n),
            .wr_sec    (wr_sec_en[i*SEC_COUNT +: SEC_COUNT]),
            .wr_data   (wr_data),
            .alloc_sec (alloc_sec_en[i*SEC_COUNT +: SEC_COUNT]),
            .alloc_id  (alloc_id),
            .bcast_en  (bcast_en),
            .bcast_id  (bcast_id),
            .tag_flush (tag_flush),
            .value     (values[i*REG_W +: REG_W]),
            .sec_valid (valids[i*SEC_COUNT +: SEC_COUNT])
        );
    end

    gpr_read_port u_read_port (
        .rd_addr    (rd_addr),
        .rd_size    (rd_size),
        .values     (values),
        .valids     (valids),
        .rd_data    (rd_data),
        .rd_pending (rd_pending)
    );

endmodule

/* dv/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;  // Released on a rising edge
    end

endmodule

/* dv/regfile_tb.sv */
`timescale 1ns/1ps

module regfile_tb
    import regfile_pkg::*;
();

    localparam int    TAG_W     = 7;
    localparam int    MAX_LINES = 1000;  // Bound on the stimulus loop
    localparam int    RST_WAIT  = 50;
    localparam string STIM_FILE = "dv/regfile_stim.txt";

    logic                  clk;
    logic                  rst_n;
    logic                  wr_en;
    logic [GPR_ADDR_W-1:0] wr_addr;
    size_t                 wr_size;
    logic [REG_W-1:0]      wr_data;
    logic                  alloc_en;
    logic [GPR_ADDR_W-1:0] alloc_addr;
    size_t                 alloc_size;
    logic [TAG_W-1:0]      alloc_id;
    logic                  bcast_en;
    logic [TAG_W-1:0]      bcast_id;
    logic                  tag_flush;
    logic [GPR_ADDR_W-1:0] rd_addr;
    size_t                 rd_size;
    logic [REG_W-1:0]      rd_data;
    logic [SEC_COUNT-1:0]  rd_pending;

    int          fd;
    int          code;
    int          line_no;
    int          data_errs;
    int          pend_errs;
    int          other_errs;
    logic        stop;
    string       op;
    logic [31:0] f_addr;
    logic [31:0] f_size;
    logic [31:0] f_val;
    logic [31:0] f_aux;

    tb_clock #(
        .PERIOD_NS  (20),
        .RST_CYCLES (5)
    ) u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    regfile_top #(
        .TAG_W (TAG_W)
    ) u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_size    (wr_size),
        .wr_data    (wr_data),
        .alloc_en   (alloc_en),
        .alloc_addr (alloc_addr),
        .alloc_size (alloc_size),
        .alloc_id   (alloc_id),
        .bcast_en   (bcast_en),
        .bcast_id   (bcast_id),
        .tag_flush  (tag_flush),
        .rd_addr    (rd_addr),
        .rd_size    (rd_size),
        .rd_data    (rd_data),
        .rd_pending (rd_pending)
    );

    // Eat the rest of a comment line
    task automatic skip_line();
        int ch;
        ch = 0;
        while (ch != 10 && ch != -1) begin  // 10 is newline
            ch = $fgetc(fd);
        end
    endtask

    task automatic report_bad_line();
        $display("Malformed stimulus at line %0d, operation %s", line_no, op);
        other_errs++;
        stop = 1'b1;
    endtask

    task automatic check_read(input logic [31:0] exp_data, input logic [31:0] exp_pend);
        if (rd_data !== exp_data) begin
            data_errs++;
            $display("[ERROR] line %0d: rd_data expected %h, got %h", line_no, exp_data, rd_data);
        end
        if (rd_pending !== exp_pend[SEC_COUNT-1:0]) begin
            pend_errs++;
            $display("[ERROR] line %0d: rd_pending expected %h, got %h",
                     line_no, exp_pend[SEC_COUNT-1:0], rd_pending);
        end
    endtask

    // One stimulus line per clock cycle
    task automatic run_op();
        @(posedge clk);
        wr_en     <= 1'b0;
        alloc_en  <= 1'b0;
        bcast_en  <= 1'b0;
        tag_flush <= 1'b0;
        if (op == "W") begin
            code = $fscanf(fd, "%h %h %h", f_addr, f_size, f_val);
            if (code != 3) begin
                report_bad_line();
            end else begin
                wr_en   <= 1'b1;
                wr_addr <= f_addr[GPR_ADDR_W-1:0];
                wr_size <= size_t'(f_size[1:0]);
                wr_data <= f_val;
            end
        end else if (op == "A" || op == "AB") begin
            if (op == "AB") begin
                code = $fscanf(fd, "%h %h %h %h", f_addr, f_size, f_val, f_aux) - 1;
            end else begin
                code = $fscanf(fd, "%h %h %h", f_addr, f_size, f_val);
            end
            if (code != 3) begin
                report_bad_line();
            end else begin
                alloc_en   <= 1'b1;
                alloc_addr <= f_addr[GPR_ADDR_W-1:0];
                alloc_size <= size_t'(f_size[1:0]);
                alloc_id   <= f_val[TAG_W-1:0];
                if (op == "AB") begin
                    bcast_en <= 1'b1;
                    bcast_id <= f_aux[TAG_W-1:0];
                end
            end
        end else if (op == "B") begin
            code = $fscanf(fd, "%h", f_val);
            if (code != 1) begin
                report_bad_line();
            end else begin
                bcast_en <= 1'b1;
                bcast_id <= f_val[TAG_W-1:0];
            end
        end else if (op == "F") begin
            tag_flush <= 1'b1;
        end else if (op == "R") begin
            code = $fscanf(fd, "%h %h %h %h", f_addr, f_size, f_val, f_aux);
            if (code != 4) begin
                report_bad_line();
            end else begin
                rd_addr <= f_addr[GPR_ADDR_W-1:0];
                rd_size <= size_t'(f_size[1:0]);
                @(negedge clk);  // Read path settled
                check_read(f_val, f_aux);
            end
        end else if (op != "N") begin
            $display("Unknown operation %s at line %0d", op, line_no);
            other_errs++;
            stop = 1'b1;
        end
    endtask

    initial begin
        int wait_cycles;
        wr_en      = 1'b0;
        wr_addr    = '0;
        wr_size    = SIZE_32;
        wr_data    = '0;
        alloc_en   = 1'b0;
        alloc_addr = '0;
        alloc_size = SIZE_32;
        alloc_id   = '0;
        bcast_en   = 1'b0;
        bcast_id   = '0;
        tag_flush  = 1'b0;
        rd_addr    = '0;
        rd_size    = SIZE_32;
        data_errs  = 0;
        pend_errs  = 0;
        other_errs = 0;
        line_no    = 0;
        fd         = 0;
        stop       = 1'b0;

        wait_cycles = 0;
        while (rst_n !== 1'b1 && wait_cycles < RST_WAIT) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("Reset was not released within %0d cycles", RST_WAIT);
            other_errs++;
            stop = 1'b1;
        end

        if (!stop) begin
            fd = $fopen(STIM_FILE, "r");
            if (fd == 0) begin
                $display("Cannot open stimulus file %s", STIM_FILE);
                other_errs++;
                stop = 1'b1;
            end
        end

        while (!stop && line_no < MAX_LINES) begin
            code = $fscanf(fd, "%s", op);
            if (code != 1) begin
                stop = 1'b1;  // End of file
            end else begin
                line_no++;
                if (op.getc(0) == 8'h23) begin
                    skip_line();
                end else begin
                    run_op();
                end
            end
        end
        if (line_no >= MAX_LINES) begin
            $display("Stimulus file has more than %0d lines, run stopped", MAX_LINES);
            other_errs++;
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        @(posedge clk);
        wr_en     <= 1'b0;
        alloc_en  <= 1'b0;
        bcast_en  <= 1'b0;
        tag_flush <= 1'b0;

        $display("Errors: rd_data %0d, rd_pending %0d, other %0d",
                 data_errs, pend_errs, other_errs);
        if (data_errs + pend_errs + other_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* dv/regfile_stim.txt */
# W addr size data | A addr size id | B id | AB addr size id bcast_id | F | N
# R addr size expected_data expected_pending ; all fields hex, size 0=8 1=16 2=32
R 0 2 00000000 0
R 1 2 00000000 0
R 2 2 00000000 0
R 3 2 00000000 0
R 4 2 00000000 0
R 5 2 00000000 0
R 6 2 00000000 0
R 7 2 00000000 0
W 1 2 8badf00d
R 1 2 8badf00d 0
R 1 1 fffff00d 0
R 1 0 0000000d 0
R 5 0 fffffff0 0
W 2 2 12345678
R 2 1 00005678 0
R 6 0 00000056 0
R 2 0 00000078 0
W 6 0 000000a5
R 2 2 1234a578 0
R 6 2 00000000 0
W 1 1 00007f01
R 1 2 8bad7f01 0
R 1 1 00007f01 0
A 3 2 11
R 3 2 00000000 7
B 22
R 3 2 00000000 7
B 11
R 3 2 00000000 0
A 0 0 05
A 4 0 06
R 0 2 00000000 3
R 0 0 00000000 1
R 4 0 00000000 1
R 0 1 00000000 3
B 05
R 0 2 00000000 2
R 4 0 00000000 1
R 0 0 00000000 0
B 06
R 0 2 00000000 0
AB 7 0 09 09
R 3 2 00000000 2
R 7 0 00000000 1
B 09
R 3 2 00000000 0
W 3 2 cafe0042
A 3 2 21
A 5 1 22
A 0 0 23
N
R 3 2 cafe0042 7
R 5 2 00000000 3
R 0 0 00000000 1
F
R 3 2 cafe0042 0
R 5 2 00000000 0
R 0 2 00000000 0
R 1 2 8bad7f01 0
R 2 2 1234a578 0

/* all.f */
src/regfile_pkg.sv
src/gpr_section_decode.sv
src/gpr_slot.sv
src/gpr_read_port.sv
src/regfile_top.sv
dv/tb_clock.sv
dv/regfile_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the register file testbench with Verilator.
# Run from anywhere; paths are taken relative to the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module regfile_tb \
    -f all.f -o sim_regfile \
    && ./obj_dir/sim_regfile | tee /dev/stderr | grep -q "^TB PASSED$" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
